// File: Bender.yml
package:
  name: wiener_denoise

sources:
  - include_dirs:
      - src
    files:
      - src/wiener_pkg.sv
      - src/block_stats.sv
      - src/block_buffer.sv
      - src/wiener_gain_div.sv
      - src/wiener_calc.sv
      - src/wiener_denoise_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - test/wiener_denoise_sva.sv
      - test/wiener_denoise_tb.sv

// File: src/block_buffer.sv
`timescale 1ns/1ns
`include "wiener_settings.svh"

module block_buffer import wiener_pkg::*; (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        wr_valid,
	input  pixel_beat_t wr_beat,
	input  logic        rd_en,
	output logic        rd_valid,
	output pixel_beat_t rd_beat
);

	localparam int PW = `WD_PIX_W;
	localparam int AW = `WD_BLOCK_LOG2;

	// two banks side by side, bank select is the top address bit
	logic [PW-1:0] mem [0:2*`WD_BLOCK_N-1];

	logic [AW-1:0] wr_addr;
	logic          wr_bank;     // bank being filled by block_stats
	logic [AW-1:0] rd_addr;
	logic          rd_bank;     // bank being drained by wiener_calc
	logic          rd_wrap;     // final entry of the read bank
	logic [PW-1:0] rd_pixel_q;
	logic          rd_last_q;

	assign rd_wrap = (rd_addr == AW'(`WD_BLOCK_N - 1));

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_addr   <= '0;
			wr_bank   <= 1'b0;
			rd_addr   <= '0;
			rd_bank   <= 1'b0;
			rd_valid  <= 1'b0;
			rd_last_q <= 1'b0;
		end else begin
			if (wr_valid) begin
				wr_addr <= wr_addr + 1'b1;   // wraps together with the last flag
				if (wr_beat.last) begin
					wr_bank <= ~wr_bank;     // block complete, fill the other bank
				end
			end
			rd_valid  <= rd_en;              // registered read, one cycle latency
			rd_last_q <= rd_en & rd_wrap;
			if (rd_en) begin
				rd_addr <= rd_addr + 1'b1;
				if (rd_wrap) begin
					rd_bank <= ~rd_bank;     // drained, move on
				end
			end
		end
	end

	// memory and read data register
	always_ff @(posedge clk) begin
		if (wr_valid) begin
			mem[{wr_bank, wr_addr}] <= wr_beat.pixel;
		end
		if (rd_en) begin
			rd_pixel_q <= mem[{rd_bank, rd_addr}];
		end
	end

	assign rd_beat = '{pixel: rd_pixel_q, last: rd_last_q};

endmodule

// File: src/block_stats.sv
`timescale 1ns/1ns
`include "wiener_settings.svh"

module block_stats import wiener_pkg::*; (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 in_valid,
	input  logic [`WD_PIX_W-1:0] in_pixel,
	output logic                 wr_valid,
	output pixel_beat_t          wr_beat,
	output logic                 stats_valid,
	output block_stats_t         stats
);

	localparam int PW    = `WD_PIX_W;
	localparam int CNT_W = `WD_BLOCK_LOG2;
	localparam int SUM_W = PW + CNT_W;      // 64 * 255 fits in 14 bits
	localparam int SQ_W  = 2 * PW + CNT_W;  // 64 * 255^2 needs 22 bits

	logic [CNT_W-1:0] pix_cnt;     // position inside the block
	logic [SUM_W-1:0] sum_acc;
	logic [SQ_W-1:0]  sq_acc;
	logic [SUM_W-1:0] sum_next;    // sums including the current pixel
	logic [SQ_W-1:0]  sq_next;
	logic [2*PW-1:0]  pix_sq;
	logic             blk_last;
	logic [PW-1:0]    mean_w;
	logic [2*PW-1:0]  ex2_w;       // mean of squares
	logic [2*PW-1:0]  var_w;
	logic [PW-1:0]    wr_pixel_q;
	logic             wr_last_q;

	assign pix_sq   = in_pixel * in_pixel;
	assign sum_next = sum_acc + SUM_W'(in_pixel);
	assign sq_next  = sq_acc + SQ_W'(pix_sq);
	assign blk_last = (pix_cnt == CNT_W'(`WD_BLOCK_N - 1));

	// divide by 64 is taking the top bits
	assign mean_w = sum_next[SUM_W-1 -: PW];
	assign ex2_w  = sq_next[SQ_W-1 -: 2*PW];
	// floor(E[x^2]) >= floor(E[x])^2, so this never goes negative
	assign var_w  = ex2_w - mean_w * mean_w;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pix_cnt     <= '0;
			sum_acc     <= '0;
			sq_acc      <= '0;
			wr_valid    <= 1'b0;
			wr_last_q   <= 1'b0;
			stats_valid <= 1'b0;
		end else begin
			wr_valid    <= in_valid;             // write follows the strobe by one
			wr_last_q   <= in_valid & blk_last;
			stats_valid <= in_valid & blk_last;  // one cycle after the 64th pixel
			if (in_valid) begin
				pix_cnt <= pix_cnt + 1'b1;       // wraps at 64 by width
				if (blk_last) begin
					sum_acc <= '0;               // fresh block
					sq_acc  <= '0;
				end else begin
					sum_acc <= sum_next;
					sq_acc  <= sq_next;
				end
			end
		end
	end

	// payload path
	always_ff @(posedge clk) begin
		if (in_valid) begin
			wr_pixel_q <= in_pixel;
		end
		if (in_valid && blk_last) begin
			stats <= '{mean: 16'(mean_w), variance: var_w};
		end
	end

	assign wr_beat = '{pixel: wr_pixel_q, last: wr_last_q};

endmodule

// File: src/wiener_calc.sv
`timescale 1ns/1ns
`include "wiener_settings.svh"

module wiener_calc import wiener_pkg::*; (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        gain_valid,
	input  gain_t       gain,
	input  logic        rd_valid,
	input  pixel_beat_t rd_beat,
	output logic        rd_en,
	output logic        out_valid,
	output pixel_beat_t out_beat
);

	localparam int PW     = `WD_PIX_W;
	localparam int QW     = 32;
	localparam int PROD_W = QW + PW;       // gain * |pixel - mean|
	localparam int CORR_W = PROD_W - 16;   // after dropping the fraction
	localparam int RES_W  = CORR_W + 2;    // room for sign and carry

	typedef enum logic {
		IDLE,
		READ
	} state_t;

	state_t                   state;
	state_t                   state_next;
	logic                     beat_last;
	logic                     pix_ge;      // pixel >= mean
	logic [PW-1:0]            abs_diff;
	logic [PROD_W-1:0]        prod;
	logic [CORR_W-1:0]        corr;
	logic signed [RES_W-1:0]  res;
	logic [PW-1:0]            clipped;
	logic [PW-1:0]            out_pixel_q;
	logic                     out_last_q;

	// the buffer flags its final entry, so no sample counter here
	assign beat_last = rd_valid & rd_beat.last;
	// drop rd_en as the last beat returns, 64 reads exactly
	assign rd_en     = (state == READ) & ~beat_last;

	always_comb begin
		state_next = state;
		case (state)
			IDLE: begin
				if (gain_valid) begin
					state_next = READ;   // stats and gain ready, drain the bank
				end
			end
			READ: begin
				if (beat_last) begin
					state_next = IDLE;
				end
			end
			default: begin
				state_next = IDLE;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= IDLE;
		end else begin
			state <= state_next;
		end
	end

	// wiener correction
	assign pix_ge   = (rd_beat.pixel >= gain.mean);
	assign abs_diff = pix_ge ? rd_beat.pixel - gain.mean : gain.mean - rd_beat.pixel;
	assign prod     = gain.quotient * abs_diff;
	assign corr     = prod[PROD_W-1:16];       // >> 16, truncated

	always_comb begin
		if (gain.positive == pix_ge) begin
			res = $signed({{(RES_W-PW){1'b0}}, gain.mean}) + $signed({2'b00, corr});
		end else begin
			res = $signed({{(RES_W-PW){1'b0}}, gain.mean}) - $signed({2'b00, corr});
		end
		// clip into the pixel range
		if (res < 0) begin
			clipped = '0;
		end else if (res > 255) begin
			clipped = '1;
		end else begin
			clipped = res[PW-1:0];
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_valid  <= 1'b0;
			out_last_q <= 1'b0;
		end else begin
			out_valid  <= rd_valid;                   // one cycle behind the read data
			out_last_q <= rd_valid & rd_beat.last;
		end
	end

	always_ff @(posedge clk) begin
		if (rd_valid) begin
			out_pixel_q <= clipped;
		end
	end

	assign out_beat = '{pixel: out_pixel_q, last: out_last_q};

endmodule

// File: src/wiener_denoise_top.sv
`timescale 1ns/1ns
`include "wiener_settings.svh"

module wiener_denoise_top import wiener_pkg::*; (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 in_valid,
	input  logic [`WD_PIX_W-1:0] in_pixel,
	input  logic [15:0]          noise_variance,  // static during a block
	output logic                 out_valid,
	output pixel_beat_t          out_beat
);

	logic         wr_valid;
	pixel_beat_t  wr_beat;
	logic         stats_valid;
	block_stats_t stats;
	logic         gain_valid;
	gain_t        gain;
	logic         rd_en;
	logic         rd_valid;
	pixel_beat_t  rd_beat;

	// producer, per-block mean and variance
	block_stats block_stats_inst (
		.clk         (clk),
		.rst_n       (rst_n),
		.in_valid    (in_valid),
		.in_pixel    (in_pixel),
		.wr_valid    (wr_valid),
		.wr_beat     (wr_beat),
		.stats_valid (stats_valid),
		.stats       (stats)
	);

	// ping-pong store while the gain is formed
	block_buffer block_buffer_inst (
		.clk      (clk),
		.rst_n    (rst_n),
		.wr_valid (wr_valid),
		.wr_beat  (wr_beat),
		.rd_en    (rd_en),
		.rd_valid (rd_valid),
		.rd_beat  (rd_beat)
	);

	wiener_gain_div wiener_gain_div_inst (
		.clk            (clk),
		.rst_n          (rst_n),
		.stats_valid    (stats_valid),
		.stats          (stats),
		.noise_variance (noise_variance),
		.gain_valid     (gain_valid),
		.gain           (gain)
	);

	wiener_calc wiener_calc_inst (
		.clk        (clk),
		.rst_n      (rst_n),
		.gain_valid (gain_valid),
		.gain       (gain),
		.rd_valid   (rd_valid),
		.rd_beat    (rd_beat),
		.rd_en      (rd_en),
		.out_valid  (out_valid),
		.out_beat   (out_beat)
	);

endmodule

// File: src/wiener_gain_div.sv
`timescale 1ns/1ns
`include "wiener_settings.svh"

module wiener_gain_div import wiener_pkg::*; (
	input  logic         clk,
	input  logic         rst_n,
	input  logic         stats_valid,
	input  block_stats_t stats,
	input  logic [15:0]  noise_variance,
	output logic         gain_valid,
	output gain_t        gain
);

	localparam int QW = 32;                    // 16.16 quotient
	localparam int DW = 16;                    // divisor and remainder
	localparam int CW = $clog2(`WD_DIV_ITER);

	logic                 busy;
	logic [CW-1:0]        iter_cnt;
	logic                 last_iter;
	logic [QW-1:0]        nq_q;       // numerator shifts out the top, quotient in the bottom
	logic [DW-1:0]        rem_q;
	logic [DW-1:0]        div_q;
	logic                 pos_q;
	logic [`WD_PIX_W-1:0] mean_q;
	logic                 var_ge;
	logic [DW-1:0]        var_diff;
	logic [DW:0]          rem_shift;
	logic                 fits;
	logic [DW-1:0]        rem_next;
	logic [QW-1:0]        nq_next;

	assign var_ge   = (stats.variance >= noise_variance);
	assign var_diff = var_ge ? stats.variance - noise_variance
	                         : noise_variance - stats.variance;

	// one restoring step
	assign rem_shift = {rem_q, nq_q[QW-1]};
	assign fits      = (rem_shift >= {1'b0, div_q});
	assign rem_next  = fits ? DW'(rem_shift - {1'b0, div_q}) : rem_shift[DW-1:0];
	assign nq_next   = {nq_q[QW-2:0], fits};
	assign last_iter = busy & (iter_cnt == CW'(`WD_DIV_ITER - 1));

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy       <= 1'b0;
			iter_cnt   <= '0;
			gain_valid <= 1'b0;
		end else begin
			gain_valid <= last_iter;  // 33 cycles after stats_valid
			if (stats_valid) begin
				busy     <= 1'b1;
				iter_cnt <= '0;
			end else if (busy) begin
				iter_cnt <= iter_cnt + 1'b1;
				if (last_iter) begin
					busy <= 1'b0;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (stats_valid) begin
			nq_q   <= {var_diff, 16'h0000};                            // |var - noise| << 16
			rem_q  <= '0;
			div_q  <= (stats.variance == '0) ? DW'(1) : stats.variance;  // flat block
			pos_q  <= var_ge;
			mean_q <= stats.mean[`WD_PIX_W-1:0];
		end else if (busy) begin
			nq_q  <= nq_next;
			rem_q <= rem_next;
			if (last_iter) begin
				gain <= '{quotient: nq_next, positive: pos_q, mean: mean_q};
			end
		end
	end

endmodule

// File: src/wiener_pkg.sv
`include "wiener_settings.svh"

package wiener_pkg;

	// one pixel on its way through the pipe
	// last marks the final pixel of a block
	typedef struct packed {
		logic [`WD_PIX_W-1:0] pixel;
		logic                 last;   // 64th pixel of the block
	} pixel_beat_t;

	// block statistics from block_stats to the divider
	typedef struct packed {
		logic [15:0] mean;      // sum / 64, truncated
		logic [15:0] variance;  // sumsq / 64 - mean^2
	} block_stats_t;

	// gain from the divider to wiener_calc
	// the mean rides along so the filter needs no second copy of the stats
	typedef struct packed {
		logic [31:0]          quotient;  // unsigned 16.16
		logic                 positive;  // block variance >= noise variance
		logic [`WD_PIX_W-1:0] mean;
	} gain_t;

endpackage

// File: src/wiener_settings.svh
`ifndef WIENER_SETTINGS_SVH
`define WIENER_SETTINGS_SVH

// pixel depth in bits, also the width of the mean carried with the gain
`define WD_PIX_W 8

// samples per block, a power of two so the mean is a plain shift
`define WD_BLOCK_N 64

// log2 of the block size, sets counter widths and the divide-by-64 shifts
`define WD_BLOCK_LOG2 6

// restoring divider steps, one quotient bit each
`define WD_DIV_ITER 32

`endif

// File: test/wiener_denoise_sva.sv
`timescale 1ns/1ns
`include "wiener_settings.svh"

module wiener_denoise_sva import wiener_pkg::*; (
	input logic        clk,
	input logic        rst_n,
	input logic        stats_valid,
	input logic        gain_valid,
	input logic        out_valid,
	input pixel_beat_t out_beat
);

	localparam int GAIN_LAT = `WD_DIV_ITER + 1;  // iterations plus the output register

	// divider answers a fixed number of cycles after the stats
	property gain_after_stats;
		@(posedge clk) disable iff (!rst_n)
		stats_valid |-> ##GAIN_LAT gain_valid;
	endproperty

	// and never without a request
	property gain_has_stats;
		@(posedge clk) disable iff (!rst_n)
		gain_valid |-> $past(stats_valid, GAIN_LAT);
	endproperty

	// divider is busy for the 32 cycles after a request
	property stats_not_while_busy;
		@(posedge clk) disable iff (!rst_n)
		stats_valid |=> (!stats_valid) [*GAIN_LAT-1];
	endproperty

	property last_only_with_valid;
		@(posedge clk) disable iff (!rst_n)
		out_beat.last |-> out_valid;
	endproperty

	assert property (gain_after_stats)
	else $error("gain_valid did not follow stats_valid after %0d cycles", GAIN_LAT);

	assert property (gain_has_stats)
	else $error("gain_valid without a matching stats_valid");

	assert property (stats_not_while_busy)
	else $error("stats_valid while the divider was busy");

	assert property (last_only_with_valid)
	else $error("out_beat.last set without out_valid");

endmodule

bind wiener_denoise_top wiener_denoise_sva wiener_denoise_sva_inst (
	.clk         (clk),
	.rst_n       (rst_n),
	.stats_valid (stats_valid),
	.gain_valid  (gain_valid),
	.out_valid   (out_valid),
	.out_beat    (out_beat)
);

// File: test/wiener_denoise_tb.sv
`timescale 1ns/1ns
`include "wiener_settings.svh"

module wiener_denoise_tb import wiener_pkg::*; ();

	localparam int N           = `WD_BLOCK_N;
	localparam int OUT_TIMEOUT = 1000;  // cycles allowed before a block's first output
	localparam int LATENCY     = 37;    // last input strobe to first out_valid
	localparam int NUM_BLOCKS  = 11;
	localparam int DRAIN       = 60;    // quiet cycles checked after the last block

	// block flavours
	localparam int RANDOM = 0;
	localparam int LOW    = 1;  // tight spread around mid grey, variance below noise
	localparam int FLAT   = 2;  // constant, variance 0
	localparam int HIGH   = 3;  // pixels near black or near white

	logic        clk;
	logic        rst_n;
	logic        in_valid;
	logic [7:0]  in_pixel;
	logic [15:0] noise_variance;
	logic        out_valid;
	pixel_beat_t out_beat;

	longint      cyc;                 // posedge count, stable at the falling edge
	logic [31:0] lfsr_state;
	logic [7:0]  blk_pix [0:N-1];     // block being driven
	pixel_beat_t exp_q [$];           // model output, in order
	longint      strobe_q [$];        // cycle of each block's last input strobe

	wiener_denoise_top wiener_denoise_top_inst (
		.clk            (clk),
		.rst_n          (rst_n),
		.in_valid       (in_valid),
		.in_pixel       (in_pixel),
		.noise_variance (noise_variance),
		.out_valid      (out_valid),
		.out_beat       (out_beat)
	);

	initial clk = 1'b0;
	always #50 clk = ~clk;  // 100 ns period

	always @(posedge clk) begin
		cyc <= cyc + 1;
	end

	// galois form, x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 32'h8020_0003;
		end
		return s >> 1;
	endfunction

	// one lfsr step per bit taken
	function automatic logic [15:0] take_bits(input int n);
		logic [15:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[14:0], lfsr_state[0]};
		end
		return v;
	endfunction

	task automatic report_mismatch(input string sig, input logic [63:0] expv,
	                               input logic [63:0] actv);
		$display("** Error: %s expected 0x%0h actual 0x%0h at cycle %0d", sig, expv, actv, cyc);
		$display("sim failed");
		$fatal(1, "stopping at the first error");
	endtask

	task automatic report_failure(input string what);
		$display("Error at cycle %0d: %s", cyc, what);
		$display("sim failed");
		$fatal(1, "stopping at the first error");
	endtask

	task automatic build_block(input int kind);
		logic [7:0] level;
		level = 8'(take_bits(8));           // only used by flat blocks
		for (int i = 0; i < N; i++) begin
			case (kind)
				LOW:     blk_pix[i] = 8'd120 + 8'(take_bits(4));
				FLAT:    blk_pix[i] = level;
				HIGH:    blk_pix[i] = take_bits(1) ? 8'd240 + 8'(take_bits(4)) : 8'(take_bits(4));
				default: blk_pix[i] = 8'(take_bits(8));
			endcase
		end
	endtask

	// integer wiener rules, straight from the block definition
	task automatic expect_block(input int nv);
		longint      sum;
		longint      sumsq;
		longint      mean;
		longint      var_b;
		longint      diff;
		longint      divisor;
		longint      quot;
		longint      p;
		longint      ad;
		longint      corr;
		longint      res;
		bit          positive;
		bit          ge;
		pixel_beat_t beat;
		sum   = 0;
		sumsq = 0;
		for (int i = 0; i < N; i++) begin
			p = blk_pix[i];
			sum   += p;
			sumsq += p * p;
		end
		mean     = sum / N;
		var_b    = sumsq / N - mean * mean;
		positive = (var_b >= nv);
		diff     = positive ? var_b - nv : nv - var_b;
		divisor  = (var_b == 0) ? 1 : var_b;
		quot     = (diff << 16) / divisor;           // 16.16 gain magnitude
		for (int i = 0; i < N; i++) begin
			p    = blk_pix[i];
			ge   = (p >= mean);
			ad   = ge ? p - mean : mean - p;
			corr = (quot * ad) >> 16;
			res  = (positive == ge) ? mean + corr : mean - corr;
			if (res < 0) res = 0;
			if (res > 255) res = 255;
			beat.pixel = res[7:0];
			beat.last  = (i == N - 1);
			exp_q.push_back(beat);
		end
	endtask

	// tight blocks use the minimum gap of one idle cycle
	task automatic drive_block(input int kind, input int nv, input bit tight);
		int gap;
		build_block(kind);
		expect_block(nv);
		noise_variance = nv[15:0];  // previous block already latched its value
		for (int i = 0; i < N; i++) begin
			in_valid = 1'b1;
			in_pixel = blk_pix[i];
			if (i == N - 1) begin
				strobe_q.push_back(cyc);
			end
			@(negedge clk);
			in_valid = 1'b0;
			gap = tight ? 1 : 1 + int'(take_bits(2));  // 1 to 4 idle cycles
			repeat (gap) @(negedge clk);
		end
	endtask

	task automatic check_block_output();
		int          waited;
		longint      start;
		pixel_beat_t expb;
		waited = 0;
		while (!out_valid) begin
			@(negedge clk);
			waited++;
			assert (waited <= OUT_TIMEOUT)
			else report_failure("no output arrived for a pending block");
		end
		assert (strobe_q.size() > 0)
		else report_failure("out_valid rose while no block was pending");
		start = strobe_q.pop_front();
		assert (cyc - start == LATENCY)
		else report_mismatch("out_valid start offset", LATENCY, cyc - start);
		for (int k = 0; k < N; k++) begin
			expb = exp_q.pop_front();
			assert (out_valid)
			else report_mismatch("out_valid", 1, out_valid);    // beats are back to back
			assert (out_beat.pixel == expb.pixel)
			else report_mismatch("out_beat.pixel", expb.pixel, out_beat.pixel);
			assert (out_beat.last == expb.last)
			else report_mismatch("out_beat.last", expb.last, out_beat.last);
			@(negedge clk);
		end
		assert (!out_valid)
		else report_mismatch("out_valid", 0, out_valid);        // exactly 64 strobes
	endtask

	initial begin
		rst_n          = 1'b0;
		in_valid       = 1'b0;
		in_pixel       = '0;
		noise_variance = '0;
		cyc            = 0;
		lfsr_state     = 32'd86276;
		repeat (10) @(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		fork
			begin
				drive_block(RANDOM, 400, 1'b0);
				drive_block(RANDOM, 400, 1'b0);
				drive_block(LOW, 600, 1'b0);      // negative gain, clips both ways
				drive_block(FLAT, 300, 1'b0);     // divisor forced to 1
				drive_block(HIGH, 2000, 1'b0);
				drive_block(HIGH, 20000, 1'b0);   // high contrast but noise dominates
				drive_block(RANDOM, 0, 1'b1);     // unit gain, back to back from here
				drive_block(RANDOM, 9000, 1'b1);
				drive_block(FLAT, 1000, 1'b1);
				drive_block(LOW, 600, 1'b1);
				drive_block(RANDOM, 400, 1'b1);
			end
			begin
				repeat (NUM_BLOCKS) check_block_output();
			end
		join
		// nothing more may come out once every block is drained
		for (int i = 0; i < DRAIN; i++) begin
			@(negedge clk);
			assert (!out_valid)
			else report_failure("out_valid rose after all blocks were drained");
		end
		if (exp_q.size() == 0 && strobe_q.size() == 0) begin
			$display("sim passed");
			$finish;
		end else begin
			$display("sim failed");
			$fatal(1, "expected output left unchecked");
		end
	end

endmodule

// File: wiener_denoise.f
+incdir+src
src/wiener_pkg.sv
src/block_stats.sv
src/block_buffer.sv
src/wiener_gain_div.sv
src/wiener_calc.sv
src/wiener_denoise_top.sv
test/wiener_denoise_sva.sv
test/wiener_denoise_tb.sv
